// File: cache_bus_pkg.sv
/*
 * shared widths, vector types and the arbiter state encoding
 * for the l1 to l2 bridge, plus the line store constants
 */

`default_nettype none

package cache_bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int STRB_WIDTH = WORD_WIDTH / 8;

    // line geometry, 2 << OFFSET_WIDTH words per line
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_WORDS = 2 << OFFSET_WIDTH;
    localparam int LINE_WORD_BITS = $clog2(LINE_WORDS);
    localparam int WORD_BYTE_BITS = $clog2(STRB_WIDTH);

    // second-level store
    localparam int L2_DEPTH_WORDS = 256;
    localparam int L2_INDEX_WIDTH = $clog2(L2_DEPTH_WORDS);
    localparam int L2_LATENCY = 3;
    localparam int L2_LAT_CNT_WIDTH = $clog2(L2_LATENCY + 1);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [WORD_WIDTH*LINE_WORDS-1:0] line_t;
    typedef logic [STRB_WIDTH-1:0] wstrb_t;

    // word position inside a line and word index into the store
    typedef logic [LINE_WORD_BITS-1:0] line_word_t;
    typedef logic [L2_INDEX_WIDTH-1:0] l2_index_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_I_READ,
        ARB_D_READ,
        ARB_D_WRITE
    } arb_state_t;

endpackage

`default_nettype wire

// File: l1_req_arbiter.sv
/*
 * fixed priority request arbiter between the two first-level caches
 * one transaction in flight, request driven only in the idle cycle
 */

`timescale 1ns/1ps
`default_nettype none

module l1_req_arbiter import cache_bus_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  logic       icache_req,
    input  addr_t      icache_addr,

    input  logic       dcache_req,
    input  logic       dcache_wr,
    input  addr_t      dcache_addr,
    input  word_t      dcache_wdata,
    input  wstrb_t     dcache_wstrb,

    input  logic       l2_data_ok,
    output logic       l2_req,
    output logic       l2_wr,
    output addr_t      l2_addr,
    output word_t      l2_wdata,
    output wstrb_t     l2_wstrb,

    output arb_state_t owner
);

    arb_state_t state;
    arb_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // dcache write, then dcache read, then icache read
    always_comb begin
        next_state = state;
        case (state)
            ARB_IDLE: begin
                if (dcache_req) begin
                    if (dcache_wr) begin
                        next_state = ARB_D_WRITE;
                    end else begin
                        next_state = ARB_D_READ;
                    end
                end else if (icache_req) begin
                    next_state = ARB_I_READ;
                end
            end
            ARB_I_READ: begin
                if (l2_data_ok) begin
                    next_state = ARB_IDLE;
                end
            end
            ARB_D_READ: begin
                if (l2_data_ok) begin
                    next_state = ARB_IDLE;
                end
            end
            ARB_D_WRITE: begin
                if (l2_data_ok) begin
                    next_state = ARB_IDLE;
                end
            end
            default: begin
                next_state = ARB_IDLE;
            end
        endcase
    end

    // issue cycle only, all zero while a transaction is open
    always_comb begin
        l2_req   = 1'b0;
        l2_wr    = 1'b0;
        l2_addr  = '0;
        l2_wdata = '0;
        l2_wstrb = '0;
        if (state == ARB_IDLE) begin
            if (dcache_req) begin
                l2_req  = 1'b1;
                l2_wr   = dcache_wr;
                l2_addr = dcache_addr;
                if (dcache_wr) begin
                    l2_wdata = dcache_wdata;
                    l2_wstrb = dcache_wstrb;
                end
            end else if (icache_req) begin
                l2_req  = 1'b1;
                l2_addr = icache_addr;
            end
        end
    end

    assign owner = state;

endmodule

`default_nettype wire

// File: l2_line_store.sv
/*
 * stand-in for the second-level cache: word memory with a fixed
 * access latency, line assembly one word per cycle, byte-masked writes
 */

`timescale 1ns/1ps
`default_nettype none

module l2_line_store import cache_bus_pkg::*; (
    input  logic   clk,
    input  logic   rstn,

    input  logic   l2_req,
    input  logic   l2_wr,
    input  addr_t  l2_addr,
    input  word_t  l2_wdata,
    input  wstrb_t l2_wstrb,

    output logic   l2_data_ok,
    output line_t  l2_line
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_FILL,
        ST_DONE
    } store_state_t;

    store_state_t state;
    logic [L2_LAT_CNT_WIDTH-1:0] wait_cnt;
    line_word_t word_cnt;

    // operands captured in the issue cycle
    logic      op_wr;
    l2_index_t op_index;
    word_t     op_wdata;
    wstrb_t    op_wstrb;

    word_t     mem [L2_DEPTH_WORDS];
    line_t     line_q;

    l2_index_t fill_index;
    logic      fill_last;
    logic      accept;

    assign accept = (state == ST_IDLE) && l2_req;

    // aligned line base plus the running word count
    assign fill_index = {op_index[L2_INDEX_WIDTH-1:LINE_WORD_BITS], word_cnt};

    // a write needs one access cycle, a read one per word
    assign fill_last = op_wr || (word_cnt == line_word_t'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (l2_req) begin
                        state    <= ST_WAIT;
                        wait_cnt <= '0;
                    end
                end
                ST_WAIT: begin
                    if (wait_cnt == L2_LAT_CNT_WIDTH'(L2_LATENCY - 1)) begin
                        state    <= ST_FILL;
                        word_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_FILL: begin
                    if (fill_last) begin
                        state <= ST_DONE;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_wr    <= l2_wr;
            op_index <= l2_addr[WORD_BYTE_BITS +: L2_INDEX_WIDTH];
            op_wdata <= l2_wdata;
            op_wstrb <= l2_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FILL) begin
            if (op_wr) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (op_wstrb[b]) begin
                        mem[op_index][8*b +: 8] <= op_wdata[8*b +: 8];
                    end
                end
            end else begin
                line_q[WORD_WIDTH*word_cnt +: WORD_WIDTH] <= mem[fill_index];
            end
        end
    end

    // last word lands together with the pulse
    assign l2_data_ok = (state == ST_DONE);
    assign l2_line    = line_q;

endmodule

`default_nettype wire

// File: l1_resp_router.sv
/*
 * completion and line routing back to the owning cache,
 * with one held line per cache
 */

`timescale 1ns/1ps
`default_nettype none

module l1_resp_router import cache_bus_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  arb_state_t owner,
    input  logic       l2_data_ok,
    input  line_t      l2_line,

    output logic       icache_data_ok,
    output line_t      icache_line,
    output logic       dcache_data_ok,
    output line_t      dcache_line
);

    logic  i_read_ok;
    logic  d_read_ok;
    logic  d_write_ok;
    line_t icache_hold;
    line_t dcache_hold;

    assign i_read_ok  = l2_data_ok && (owner == ARB_I_READ);
    assign d_read_ok  = l2_data_ok && (owner == ARB_D_READ);
    assign d_write_ok = l2_data_ok && (owner == ARB_D_WRITE);

    // writes complete without touching the held line
    always_ff @(posedge clk) begin
        if (!rstn) begin
            icache_hold <= '0;
            dcache_hold <= '0;
        end else begin
            if (i_read_ok) begin
                icache_hold <= l2_line;
            end
            if (d_read_ok) begin
                dcache_hold <= l2_line;
            end
        end
    end

    assign icache_data_ok = i_read_ok;
    assign dcache_data_ok = d_read_ok || d_write_ok;

    // live line during the pulse, held copy after it
    assign icache_line = i_read_ok ? l2_line : icache_hold;
    assign dcache_line = d_read_ok ? l2_line : dcache_hold;

endmodule

`default_nettype wire

// File: l1_l2_bridge_top.sv
/*
 * bridge top level: request arbiter, second-level line store
 * and response router
 */

`timescale 1ns/1ps
`default_nettype none

module l1_l2_bridge_top import cache_bus_pkg::*; (
    input  logic   clk,
    input  logic   rstn,

    input  logic   icache_req,
    input  addr_t  icache_addr,
    output logic   icache_data_ok,
    output line_t  icache_line,

    input  logic   dcache_req,
    input  logic   dcache_wr,
    input  addr_t  dcache_addr,
    input  word_t  dcache_wdata,
    input  wstrb_t dcache_wstrb,
    output logic   dcache_data_ok,
    output line_t  dcache_line
);

    logic       l2_req;
    logic       l2_wr;
    addr_t      l2_addr;
    word_t      l2_wdata;
    wstrb_t     l2_wstrb;
    logic       l2_data_ok;
    line_t      l2_line;
    arb_state_t owner;

    l1_req_arbiter l1_req_arbiter_i (
        .clk          (clk),
        .rstn         (rstn),
        .icache_req   (icache_req),
        .icache_addr  (icache_addr),
        .dcache_req   (dcache_req),
        .dcache_wr    (dcache_wr),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_wstrb (dcache_wstrb),
        .l2_data_ok   (l2_data_ok),
        .l2_req       (l2_req),
        .l2_wr        (l2_wr),
        .l2_addr      (l2_addr),
        .l2_wdata     (l2_wdata),
        .l2_wstrb     (l2_wstrb),
        .owner        (owner)
    );

    l2_line_store l2_line_store_i (
        .clk        (clk),
        .rstn       (rstn),
        .l2_req     (l2_req),
        .l2_wr      (l2_wr),
        .l2_addr    (l2_addr),
        .l2_wdata   (l2_wdata),
        .l2_wstrb   (l2_wstrb),
        .l2_data_ok (l2_data_ok),
        .l2_line    (l2_line)
    );

    l1_resp_router l1_resp_router_i (
        .clk            (clk),
        .rstn           (rstn),
        .owner          (owner),
        .l2_data_ok     (l2_data_ok),
        .l2_line        (l2_line),
        .icache_data_ok (icache_data_ok),
        .icache_line    (icache_line),
        .dcache_data_ok (dcache_data_ok),
        .dcache_line    (dcache_line)
    );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
/*
 * testbench clock with an 8 ns period and a reset held low for 16 cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rstn
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released on a falling edge like the other DUT inputs
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: l1_l2_bridge_asserts.sv
/*
 * bridge bus rules covering issue only when idle, exclusive
 * completions and bounded icache service
 */

`timescale 1ns/1ps
`default_nettype none

module l1_l2_bridge_asserts import cache_bus_pkg::*; (
    input logic       clk,
    input logic       rstn,
    input logic       l2_req,
    input logic       l2_data_ok,
    input arb_state_t owner,
    input logic       icache_req,
    input logic       icache_data_ok,
    input logic       dcache_data_ok
);

    // allows a full dcache read ahead of the icache read
    localparam int ICACHE_MAX_WAIT = 4 * (L2_LATENCY + LINE_WORDS);

    int   fail_count = 0;
    logic in_flight;

    // open from an issue until the store completes it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_flight <= 1'b0;
        end else if (l2_req) begin
            in_flight <= 1'b1;
        end else if (l2_data_ok) begin
            in_flight <= 1'b0;
        end
    end

    req_only_idle: assert property (@(posedge clk) disable iff (!rstn)
        l2_req |-> owner == ARB_IDLE && !in_flight)
    else begin
        $error("l2_req raised while a transaction is open");
        fail_count++;
    end

    one_completion: assert property (@(posedge clk) disable iff (!rstn)
        !(icache_data_ok && dcache_data_ok))
    else begin
        $error("icache and dcache completed in the same cycle");
        fail_count++;
    end

    icache_served: assert property (@(posedge clk) disable iff (!rstn)
        $rose(icache_req) |-> ##[1:ICACHE_MAX_WAIT] icache_data_ok)
    else begin
        $error("icache request was not served in time");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: l1_l2_bridge_checker.sv
/*
 * watches the cache side of the bridge, compares lines and latencies
 * and reports each test as it finishes
 */

`timescale 1ns/1ps
`default_nettype none

module l1_l2_bridge_checker import cache_bus_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  icache_req,
    input  logic  dcache_req,
    input  logic  dcache_wr,
    input  logic  icache_data_ok,
    input  line_t icache_line,
    input  logic  dcache_data_ok,
    input  line_t dcache_line,
    input  line_t exp_i_line,
    input  line_t exp_d_line,
    input  logic  test_done,
    input  int    test_id,
    input  int    timeouts,
    output int    errors,
    output int    tests_passed,
    output int    tests_failed
);

    localparam int READ_LATENCY = L2_LATENCY + LINE_WORDS;
    localparam int WRITE_LATENCY = L2_LATENCY + 1;

    // cycles each req has been seen high so far
    int    i_cnt = 0;
    int    d_cnt = 0;
    logic  i_lat_chk = 1'b0;
    logic  d_lat_chk = 1'b0;
    line_t i_held = '0;
    line_t d_held = '0;
    int    err_mark = 0;
    int    to_mark = 0;
    int    test_errs;

    initial begin
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %s latency: expected 0x%h, got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            i_cnt = 0;
            d_cnt = 0;
            i_held = '0;
            d_held = '0;
        end else begin
            // latency only counts for a request that finds the bridge idle
            if (icache_req && i_cnt == 0) i_lat_chk = !dcache_req;
            if (dcache_req && d_cnt == 0) d_lat_chk = (i_cnt == 0);
            if (icache_data_ok) begin
                if (!icache_req) begin
                    $display("icache completion arrived with no request pending");
                    errors++;
                end
                check_line("icache_line", icache_line, exp_i_line);
                if (i_lat_chk) check_latency("icache_data_ok", i_cnt - 1, READ_LATENCY);
                i_held = exp_i_line;
            end
            if (dcache_data_ok) begin
                if (!dcache_req) begin
                    $display("dcache completion arrived with no request pending");
                    errors++;
                end
                if (dcache_wr) begin
                    check_line("dcache_line", dcache_line, d_held);
                    if (d_lat_chk) check_latency("dcache_data_ok", d_cnt - 1, WRITE_LATENCY);
                end else begin
                    check_line("dcache_line", dcache_line, exp_d_line);
                    if (d_lat_chk) check_latency("dcache_data_ok", d_cnt - 1, READ_LATENCY);
                    d_held = exp_d_line;
                end
                // icache keeps its earlier line
                check_line("icache_line", icache_line, i_held);
            end
            i_cnt = icache_req ? i_cnt + 1 : 0;
            d_cnt = dcache_req ? d_cnt + 1 : 0;
            if (test_done) begin
                test_errs = errors - err_mark + timeouts - to_mark;
                if (test_errs == 0) begin
                    $display("test %0d passed", test_id);
                    tests_passed++;
                end else begin
                    $display("test %0d failed with %0d errors", test_id, test_errs);
                    tests_failed++;
                end
                err_mark = errors;
                to_mark = timeouts;
            end
        end
    end

endmodule

`default_nettype wire

// File: l1_l2_bridge_tb.sv
/*
 * bridge testbench: stimulus table with expected lines from a shadow
 * word memory, applied one test at a time through both cache ports
 */

`timescale 1ns/1ps
`default_nettype none

module l1_l2_bridge_tb import cache_bus_pkg::*; ();

    localparam logic [1:0] OP_NONE = 2'd0;
    localparam logic [1:0] OP_READ = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;
    localparam int MAX_TESTS = 32;
    localparam int REQ_TIMEOUT = 64;
    localparam int RESET_TIMEOUT = 64;

    typedef struct packed {
        logic [1:0] i_op;
        logic [1:0] d_op;
        addr_t      i_addr;
        addr_t      d_addr;
        word_t      wdata;
        wstrb_t     wstrb;
        line_t      exp_i;
        line_t      exp_d;
    } test_t;

    logic   clk;
    logic   rstn;
    logic   icache_req;
    addr_t  icache_addr;
    logic   icache_data_ok;
    line_t  icache_line;
    logic   dcache_req;
    logic   dcache_wr;
    addr_t  dcache_addr;
    word_t  dcache_wdata;
    wstrb_t dcache_wstrb;
    logic   dcache_data_ok;
    line_t  dcache_line;

    line_t  exp_i_line;
    line_t  exp_d_line;
    logic   test_done;
    int     test_id;
    int     timeouts;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    int     assert_fails;
    int     total;
    int     num_tests;
    integer seed;
    test_t  tests [MAX_TESTS];
    word_t  shadow [L2_DEPTH_WORDS];

    tb_clkgen tb_clkgen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    l1_l2_bridge_top l1_l2_bridge_top_i (
        .clk            (clk),
        .rstn           (rstn),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .icache_data_ok (icache_data_ok),
        .icache_line    (icache_line),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_data_ok (dcache_data_ok),
        .dcache_line    (dcache_line)
    );

    l1_l2_bridge_checker l1_l2_bridge_checker_i (
        .clk            (clk),
        .rstn           (rstn),
        .icache_req     (icache_req),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .icache_data_ok (icache_data_ok),
        .icache_line    (icache_line),
        .dcache_data_ok (dcache_data_ok),
        .dcache_line    (dcache_line),
        .exp_i_line     (exp_i_line),
        .exp_d_line     (exp_d_line),
        .test_done      (test_done),
        .test_id        (test_id),
        .timeouts       (timeouts),
        .errors         (errors),
        .tests_passed   (tests_passed),
        .tests_failed   (tests_failed)
    );

    bind l1_l2_bridge_top l1_l2_bridge_asserts l1_l2_bridge_asserts_i (
        .clk            (clk),
        .rstn           (rstn),
        .l2_req         (l2_req),
        .l2_data_ok     (l2_data_ok),
        .owner          (owner),
        .icache_req     (icache_req),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok)
    );

    assign assert_fails = l1_l2_bridge_top_i.l1_l2_bridge_asserts_i.fail_count;

    // word index wraps at the store size and the line is the aligned group of words
    function automatic line_t line_of(input addr_t addr);
        line_t line;
        int    base;
        int    k;
        base = (addr / STRB_WIDTH) % L2_DEPTH_WORDS;
        base = base - base % LINE_WORDS;
        for (k = 0; k < LINE_WORDS; k++) begin
            line[WORD_WIDTH*k +: WORD_WIDTH] = shadow[base + k];
        end
        return line;
    endfunction

    task automatic add_test(input logic [1:0] i_op, input logic [1:0] d_op, input addr_t i_addr,
                            input addr_t d_addr, input word_t wdata, input wstrb_t wstrb);
        test_t t;
        int    idx;
        int    b;
        idx = (d_addr / STRB_WIDTH) % L2_DEPTH_WORDS;
        // dcache wins arbitration, so its write lands before a paired icache read
        if (d_op == OP_WRITE) begin
            for (b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b]) shadow[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        t.i_op = i_op;
        t.d_op = d_op;
        t.i_addr = i_addr;
        t.d_addr = d_addr;
        t.wdata = wdata;
        t.wstrb = wstrb;
        t.exp_i = (i_op == OP_READ) ? line_of(i_addr) : '0;
        t.exp_d = (d_op == OP_READ) ? line_of(d_addr) : '0;
        tests[num_tests] = t;
        num_tests++;
    endtask

    // line a at 0x40, line b at 0x13e0 which aliases to word 248
    task automatic build_table();
        int k;
        for (k = 0; k < LINE_WORDS; k++) begin
            add_test(OP_NONE, OP_WRITE, '0, 32'h40 + 4 * k, $random(seed), 4'hf);
        end
        for (k = 0; k < LINE_WORDS; k++) begin
            add_test(OP_NONE, OP_WRITE, '0, 32'h13e0 + 4 * k, $random(seed), 4'hf);
        end
        add_test(OP_NONE, OP_READ, '0, 32'h48, '0, '0);
        add_test(OP_NONE, OP_READ, '0, 32'h3e4, '0, '0);
        add_test(OP_NONE, OP_WRITE, '0, 32'h4c, $random(seed), 4'b0101);
        add_test(OP_NONE, OP_READ, '0, 32'h40, '0, '0);
        add_test(OP_READ, OP_NONE, 32'h5c, '0, '0, '0);
        add_test(OP_READ, OP_NONE, 32'h3e8, '0, '0, '0);
        add_test(OP_READ, OP_READ, 32'h3e0, 32'h54, '0, '0);
        add_test(OP_READ, OP_WRITE, 32'h44, 32'h13f4, $random(seed), 4'b1000);
        add_test(OP_NONE, OP_READ, '0, 32'h3f0, '0, '0);
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (!rstn && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rstn) begin
            $display("reset was never released");
            timeouts++;
        end
    endtask

    task automatic apply_test(input int n);
        test_t t;
        logic  i_pend;
        logic  d_pend;
        logic  i_seen;
        logic  d_seen;
        int    waited;
        t = tests[n];
        @(negedge clk);
        exp_i_line = t.exp_i;
        exp_d_line = t.exp_d;
        icache_req = (t.i_op == OP_READ);
        icache_addr = t.i_addr;
        dcache_req = (t.d_op != OP_NONE);
        dcache_wr = (t.d_op == OP_WRITE);
        dcache_addr = t.d_addr;
        dcache_wdata = t.wdata;
        dcache_wstrb = t.wstrb;
        i_pend = icache_req;
        d_pend = dcache_req;
        i_seen = 1'b0;
        d_seen = 1'b0;
        waited = 0;
        while ((i_pend || d_pend) && waited < REQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
            // req goes low the cycle after its pulse
            if (i_seen) icache_req = 1'b0;
            if (d_seen) dcache_req = 1'b0;
            if (i_pend && icache_data_ok) begin
                i_pend = 1'b0;
                i_seen = 1'b1;
            end
            if (d_pend && dcache_data_ok) begin
                d_pend = 1'b0;
                d_seen = 1'b1;
            end
        end
        if (i_pend) begin
            $display("test %0d timed out waiting for icache_data_ok", n);
            timeouts++;
        end
        if (d_pend) begin
            $display("test %0d timed out waiting for dcache_data_ok", n);
            timeouts++;
        end
        @(negedge clk);
        icache_req = 1'b0;
        dcache_req = 1'b0;
        dcache_wr = 1'b0;
        test_id = n;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        icache_req = 1'b0;
        icache_addr = '0;
        dcache_req = 1'b0;
        dcache_wr = 1'b0;
        dcache_addr = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        exp_i_line = '0;
        exp_d_line = '0;
        test_done = 1'b0;
        test_id = 0;
        timeouts = 0;
        num_tests = 0;
        seed = 85;
        build_table();
        wait_reset();
        if (rstn) begin
            for (int n = 0; n < num_tests; n++) begin
                apply_test(n);
            end
        end
        repeat (4) @(negedge clk);
        total = errors + timeouts + assert_fails;
        $display("tests %0d, passed %0d, failed %0d, errors %0d, timeouts %0d, assertions %0d",
                 num_tests, tests_passed, tests_failed, errors, timeouts, assert_fails);
        if (total == 0 && tests_failed == 0 && tests_passed == num_tests) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
cache_bus_pkg.sv
l1_req_arbiter.sv
l2_line_store.sv
l1_resp_router.sv
l1_l2_bridge_top.sv
tb_clkgen.sv
l1_l2_bridge_asserts.sv
l1_l2_bridge_checker.sv
l1_l2_bridge_tb.sv
